//--- core_cfg_pkg.sv
package core_cfg_pkg;

    // Data word width
    localparam int XLEN = 32;

    // Register index width and architectural register count
    localparam int REG_IDX_W = 5;
    localparam int NUM_REGS = 32;

    // One quotient bit per divider iteration
    localparam int DIV_STEPS = XLEN;

endpackage

//--- exec_op_pkg.sv
package exec_op_pkg;
    import core_cfg_pkg::*;

    typedef enum logic [3:0] {
        OP_LI,
        OP_ADD,
        OP_SUB,
        OP_XOR,
        OP_MUL,
        OP_MULHU,
        OP_DIV,
        OP_DIVU,
        OP_REM,
        OP_REMU
    } exec_op_e;

    typedef enum logic [1:0] {
        UNIT_ALU,
        UNIT_MUL,
        UNIT_DIV
    } unit_e;

    // Operation and operands as handed to the multiplier and the divider
    typedef struct packed {
        exec_op_e             op;
        logic [REG_IDX_W-1:0] rd;
        logic [XLEN-1:0]      a;
        logic [XLEN-1:0]      b;
    } issued_op_t;

    function automatic unit_e op_unit(input exec_op_e op);
        unit_e unit;
        unique case (op)
            OP_MUL, OP_MULHU: unit = UNIT_MUL;
            OP_DIV, OP_DIVU, OP_REM, OP_REMU: unit = UNIT_DIV;
            default: unit = UNIT_ALU;
        endcase
        return unit;
    endfunction

endpackage

//--- wb_bus_if.sv
`timescale 1ns/1ps

interface wb_bus_if import core_cfg_pkg::*; ();

    logic                 valid;
    logic                 ready;
    logic [REG_IDX_W-1:0] rd;
    logic [XLEN-1:0]      data;

    // Result producer side
    modport producer (
        output valid,
        output rd,
        output data,
        input  ready
    );

    // Write back arbiter side
    modport arbiter (
        input  valid,
        input  rd,
        input  data,
        output ready
    );

endinterface

//--- reg_file.sv
`timescale 1ns/1ps

module reg_file import core_cfg_pkg::*; (
    input  logic                 clk,
    input  logic                 resetn,

    input  logic [REG_IDX_W-1:0] i_rs1_sel,
    input  logic [REG_IDX_W-1:0] i_rs2_sel,
    output logic [XLEN-1:0]      o_rs1_data,
    output logic [XLEN-1:0]      o_rs2_data,

    input  logic                 i_we,
    input  logic [REG_IDX_W-1:0] i_w_sel,
    input  logic [XLEN-1:0]      i_w_data
);

    // x0 has no storage
    logic [XLEN-1:0] regs [1:NUM_REGS-1];

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && i_w_sel != '0) begin
            regs[i_w_sel] <= i_w_data;
        end
    end

    assign o_rs1_data = (i_rs1_sel == '0) ? '0 : regs[i_rs1_sel];
    assign o_rs2_data = (i_rs2_sel == '0) ? '0 : regs[i_rs2_sel];

endmodule

//--- issue_stage.sv
`timescale 1ns/1ps

module issue_stage import core_cfg_pkg::*; import exec_op_pkg::*; (
    input  logic                 clk,
    input  logic                 resetn,

    input  logic                 i_issue_valid,
    input  exec_op_e             i_issue_op,
    input  logic [REG_IDX_W-1:0] i_issue_rd,
    input  logic [REG_IDX_W-1:0] i_issue_rs1,
    input  logic [REG_IDX_W-1:0] i_issue_rs2,
    input  logic [XLEN-1:0]      i_issue_imm,
    output logic                 o_issue_ready,

    output logic [REG_IDX_W-1:0] o_rs1_sel,
    output logic [REG_IDX_W-1:0] o_rs2_sel,
    input  logic [XLEN-1:0]      i_rs1_data,
    input  logic [XLEN-1:0]      i_rs2_data,

    input  logic                 i_wb_valid,
    input  logic [REG_IDX_W-1:0] i_wb_rd,

    output logic                 o_mul_valid,
    output logic                 o_div_valid,
    output issued_op_t           o_op,
    input  logic                 i_mul_can_accept,
    input  logic                 i_div_busy,

    wb_bus_if.producer           alu_bus
);

    logic [NUM_REGS-1:0]  pending_q;
    logic                 active_q;
    unit_e                unit;
    logic                 hazard;
    logic                 unit_ok;
    logic                 accept;
    logic [XLEN-1:0]      alu_result;

    logic                 slot_valid_q;
    logic [REG_IDX_W-1:0] slot_rd_q;
    logic [XLEN-1:0]      slot_data_q;

    // Operands come straight from the register file
    assign o_rs1_sel = i_issue_rs1;
    assign o_rs2_sel = i_issue_rs2;

    assign unit = op_unit(i_issue_op);

    // Bit 0 is never set, so x0 never causes a stall
    assign hazard = pending_q[i_issue_rs1] || pending_q[i_issue_rs2] || pending_q[i_issue_rd];

    always_comb begin
        unique case (unit)
            UNIT_ALU: unit_ok = !slot_valid_q || alu_bus.ready;
            UNIT_MUL: unit_ok = i_mul_can_accept;
            UNIT_DIV: unit_ok = !i_div_busy;
            default:  unit_ok = 1'b0;
        endcase
    end

    assign o_issue_ready = active_q && !hazard && unit_ok;
    assign accept = i_issue_valid && o_issue_ready;

    assign o_mul_valid = accept && unit == UNIT_MUL;
    assign o_div_valid = accept && unit == UNIT_DIV;
    assign o_op = '{op: i_issue_op, rd: i_issue_rd, a: i_rs1_data, b: i_rs2_data};

    always_comb begin
        unique case (i_issue_op)
            OP_ADD:  alu_result = i_rs1_data + i_rs2_data;
            OP_SUB:  alu_result = i_rs1_data - i_rs2_data;
            OP_XOR:  alu_result = i_rs1_data ^ i_rs2_data;
            default: alu_result = i_issue_imm;
        endcase
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            pending_q <= '0;
            active_q <= 1'b0;
            slot_valid_q <= 1'b0;
        end else begin
            active_q <= 1'b1;
            if (i_wb_valid) begin
                pending_q[i_wb_rd] <= 1'b0;
            end
            if (accept && i_issue_rd != '0) begin
                pending_q[i_issue_rd] <= 1'b1;
            end

            // Slot refills on the edge it drains
            if (accept && unit == UNIT_ALU) begin
                slot_valid_q <= 1'b1;
            end else if (slot_valid_q && alu_bus.ready) begin
                slot_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept && unit == UNIT_ALU) begin
            slot_rd_q <= i_issue_rd;
            slot_data_q <= alu_result;
        end
    end

    assign alu_bus.valid = slot_valid_q;
    assign alu_bus.rd = slot_rd_q;
    assign alu_bus.data = slot_data_q;

endmodule

//--- mul_unit.sv
`timescale 1ns/1ps

module mul_unit import core_cfg_pkg::*; import exec_op_pkg::*; (
    input  logic       clk,
    input  logic       resetn,

    input  logic       i_valid,
    input  issued_op_t i_op,
    output logic       o_can_accept,

    wb_bus_if.producer mul_bus
);

    logic                 s1_valid_q;
    issued_op_t           s1_op_q;

    logic                 s2_valid_q;
    logic [REG_IDX_W-1:0] s2_rd_q;
    logic                 s2_high_q;
    logic [2*XLEN-1:0]    s2_prod_q;

    logic                 advance;

    // Whole pipe stalls while the result waits for a grant
    assign advance = !s2_valid_q || mul_bus.ready;
    assign o_can_accept = advance || !s1_valid_q;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            s1_valid_q <= 1'b0;
            s2_valid_q <= 1'b0;
        end else begin
            if (advance) begin
                s2_valid_q <= s1_valid_q;
            end
            if (o_can_accept) begin
                s1_valid_q <= i_valid;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (o_can_accept && i_valid) begin
            s1_op_q <= i_op;
        end
        if (advance && s1_valid_q) begin
            s2_rd_q <= s1_op_q.rd;
            s2_high_q <= s1_op_q.op == OP_MULHU;
            s2_prod_q <= {{XLEN{1'b0}}, s1_op_q.a} * {{XLEN{1'b0}}, s1_op_q.b};
        end
    end

    assign mul_bus.valid = s2_valid_q;
    assign mul_bus.rd = s2_rd_q;
    assign mul_bus.data = s2_high_q ? s2_prod_q[2*XLEN-1:XLEN] : s2_prod_q[XLEN-1:0];

endmodule

//--- div_unit.sv
`timescale 1ns/1ps

module div_unit import core_cfg_pkg::*; import exec_op_pkg::*; (
    input  logic       clk,
    input  logic       resetn,

    input  logic       i_valid,
    input  issued_op_t i_op,
    output logic       o_busy,

    wb_bus_if.producer div_bus
);

    logic                         busy_q;
    logic                         done_q;
    logic [$clog2(DIV_STEPS)-1:0] step_q;

    logic [XLEN-1:0]              quo_q;
    logic [XLEN-1:0]              rem_q;
    logic [XLEN-1:0]              divisor_q;
    logic [REG_IDX_W-1:0]         rd_q;
    logic                         use_rem_q;
    logic                         q_neg_q;
    logic                         r_neg_q;

    logic                         is_signed;
    logic                         a_neg;
    logic                         b_neg;
    logic [XLEN-1:0]              mag_a;
    logic [XLEN-1:0]              mag_b;
    logic [XLEN:0]                rem_shift;
    logic [XLEN:0]                trial;

    assign is_signed = i_op.op inside {OP_DIV, OP_REM};
    assign a_neg = is_signed && i_op.a[XLEN-1];
    assign b_neg = is_signed && i_op.b[XLEN-1];
    assign mag_a = a_neg ? -i_op.a : i_op.a;
    assign mag_b = b_neg ? -i_op.b : i_op.b;

    // Shift in the next dividend bit, then try to subtract
    assign rem_shift = {rem_q, quo_q[XLEN-1]};
    assign trial = rem_shift - {1'b0, divisor_q};

    // Stays busy until the result has been handed over
    assign o_busy = busy_q || done_q;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
            step_q <= '0;
        end else if (i_valid && !o_busy) begin
            busy_q <= 1'b1;
            step_q <= '0;
        end else if (busy_q) begin
            step_q <= step_q + 1'b1;
            if (int'(step_q) == DIV_STEPS - 1) begin
                busy_q <= 1'b0;
                done_q <= 1'b1;
            end
        end else if (done_q && div_bus.ready) begin
            done_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (i_valid && !o_busy) begin
            quo_q <= mag_a;
            rem_q <= '0;
            divisor_q <= mag_b;
            rd_q <= i_op.rd;
            use_rem_q <= i_op.op inside {OP_REM, OP_REMU};
            // Divide by zero keeps the all-ones quotient
            q_neg_q <= (a_neg ^ b_neg) && i_op.b != '0;
            r_neg_q <= a_neg;
        end else if (busy_q) begin
            if (!trial[XLEN]) begin
                rem_q <= trial[XLEN-1:0];
                quo_q <= {quo_q[XLEN-2:0], 1'b1};
            end else begin
                rem_q <= rem_shift[XLEN-1:0];
                quo_q <= {quo_q[XLEN-2:0], 1'b0};
            end
        end
    end

    assign div_bus.valid = done_q;
    assign div_bus.rd = rd_q;
    assign div_bus.data = use_rem_q ? (r_neg_q ? -rem_q : rem_q)
                                    : (q_neg_q ? -quo_q : quo_q);

endmodule

//--- wb_arbiter.sv
`timescale 1ns/1ps

module wb_arbiter import core_cfg_pkg::*; (
    input  logic                 clk,
    input  logic                 resetn,

    wb_bus_if.arbiter            div_bus,
    wb_bus_if.arbiter            mul_bus,
    wb_bus_if.arbiter            alu_bus,

    output logic                 o_wb_valid,
    output logic [REG_IDX_W-1:0] o_wb_rd,
    output logic [XLEN-1:0]      o_wb_data
);

    logic                 sel_valid;
    logic [REG_IDX_W-1:0] sel_rd;
    logic [XLEN-1:0]      sel_data;

    // Divider always wins
    assign div_bus.ready = 1'b1;
    assign mul_bus.ready = !div_bus.valid;
    assign alu_bus.ready = !div_bus.valid && !mul_bus.valid;

    always_comb begin
        sel_valid = 1'b1;
        if (div_bus.valid) begin
            sel_rd = div_bus.rd;
            sel_data = div_bus.data;
        end else if (mul_bus.valid) begin
            sel_rd = mul_bus.rd;
            sel_data = mul_bus.data;
        end else begin
            sel_valid = alu_bus.valid;
            sel_rd = alu_bus.rd;
            sel_data = alu_bus.data;
        end
    end

    // Results for x0 are taken but never written back
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            o_wb_valid <= 1'b0;
        end else begin
            o_wb_valid <= sel_valid && sel_rd != '0;
        end
    end

    always_ff @(posedge clk) begin
        if (sel_valid) begin
            o_wb_rd <= sel_rd;
            o_wb_data <= sel_data;
        end
    end

endmodule

//--- exec_core.sv
`timescale 1ns/1ps

module exec_core import core_cfg_pkg::*; import exec_op_pkg::*; (
    input  logic                 clk,
    input  logic                 resetn,

    input  logic                 i_issue_valid,
    output logic                 o_issue_ready,
    input  exec_op_e             i_issue_op,
    input  logic [REG_IDX_W-1:0] i_issue_rd,
    input  logic [REG_IDX_W-1:0] i_issue_rs1,
    input  logic [REG_IDX_W-1:0] i_issue_rs2,
    input  logic [XLEN-1:0]      i_issue_imm,

    output logic                 o_wb_valid,
    output logic [REG_IDX_W-1:0] o_wb_rd,
    output logic [XLEN-1:0]      o_wb_data
);

    logic [REG_IDX_W-1:0] rs1_sel;
    logic [REG_IDX_W-1:0] rs2_sel;
    logic [XLEN-1:0]      rs1_data;
    logic [XLEN-1:0]      rs2_data;
    logic                 mul_valid;
    logic                 div_valid;
    logic                 mul_can_accept;
    logic                 div_busy;
    issued_op_t           unit_op;

    wb_bus_if alu_bus ();
    wb_bus_if mul_bus ();
    wb_bus_if div_bus ();

    reg_file reg_file_inst (
        .clk        (clk),
        .resetn     (resetn),
        .i_rs1_sel  (rs1_sel),
        .i_rs2_sel  (rs2_sel),
        .o_rs1_data (rs1_data),
        .o_rs2_data (rs2_data),
        .i_we       (o_wb_valid),
        .i_w_sel    (o_wb_rd),
        .i_w_data   (o_wb_data)
    );

    issue_stage issue_stage_inst (
        .clk              (clk),
        .resetn           (resetn),
        .i_issue_valid    (i_issue_valid),
        .i_issue_op       (i_issue_op),
        .i_issue_rd       (i_issue_rd),
        .i_issue_rs1      (i_issue_rs1),
        .i_issue_rs2      (i_issue_rs2),
        .i_issue_imm      (i_issue_imm),
        .o_issue_ready    (o_issue_ready),
        .o_rs1_sel        (rs1_sel),
        .o_rs2_sel        (rs2_sel),
        .i_rs1_data       (rs1_data),
        .i_rs2_data       (rs2_data),
        .i_wb_valid       (o_wb_valid),
        .i_wb_rd          (o_wb_rd),
        .o_mul_valid      (mul_valid),
        .o_div_valid      (div_valid),
        .o_op             (unit_op),
        .i_mul_can_accept (mul_can_accept),
        .i_div_busy       (div_busy),
        .alu_bus          (alu_bus.producer)
    );

    mul_unit mul_unit_inst (
        .clk          (clk),
        .resetn       (resetn),
        .i_valid      (mul_valid),
        .i_op         (unit_op),
        .o_can_accept (mul_can_accept),
        .mul_bus      (mul_bus.producer)
    );

    div_unit div_unit_inst (
        .clk     (clk),
        .resetn  (resetn),
        .i_valid (div_valid),
        .i_op    (unit_op),
        .o_busy  (div_busy),
        .div_bus (div_bus.producer)
    );

    wb_arbiter wb_arbiter_inst (
        .clk        (clk),
        .resetn     (resetn),
        .div_bus    (div_bus.arbiter),
        .mul_bus    (mul_bus.arbiter),
        .alu_bus    (alu_bus.arbiter),
        .o_wb_valid (o_wb_valid),
        .o_wb_rd    (o_wb_rd),
        .o_wb_data  (o_wb_data)
    );

endmodule

//--- exec_core_assert.sv
`timescale 1ns/1ps

module exec_core_assert import core_cfg_pkg::*; (
    input  logic                      clk,
    input  logic                      resetn,
    input  logic                      i_wb_valid,
    input  logic [REG_IDX_W-1:0]      i_wb_rd,
    input  logic                      i_div_valid,
    input  logic                      i_div_busy,
    input  logic                      i_alu_valid,
    input  logic                      i_alu_ready,
    input  logic [REG_IDX_W+XLEN-1:0] i_alu_result,
    input  logic                      i_mul_valid,
    input  logic                      i_mul_ready,
    input  logic [REG_IDX_W+XLEN-1:0] i_mul_result,
    input  logic                      i_div_out_valid,
    input  logic                      i_div_out_ready,
    input  logic [REG_IDX_W+XLEN-1:0] i_div_result
);

    a_wb_rd_nonzero: assert property (@(posedge clk) disable iff (!resetn)
        i_wb_valid |-> i_wb_rd != '0)
        else $error("writeback strobe raised for register 0");

    a_wb_idle_in_reset: assert property (@(posedge clk) !resetn |-> !i_wb_valid)
        else $error("writeback strobe raised during reset");

    a_div_issue_idle: assert property (@(posedge clk) disable iff (!resetn)
        i_div_valid |-> !i_div_busy)
        else $error("divider issue accepted while the divider is busy");

    // Held results must not change before their grant
    a_alu_hold: assert property (@(posedge clk) disable iff (!resetn)
        i_alu_valid && !i_alu_ready |=> i_alu_valid && $stable(i_alu_result))
        else $error("ALU result dropped or changed before its grant");

    a_mul_hold: assert property (@(posedge clk) disable iff (!resetn)
        i_mul_valid && !i_mul_ready |=> i_mul_valid && $stable(i_mul_result))
        else $error("multiplier result dropped or changed before its grant");

    a_div_hold: assert property (@(posedge clk) disable iff (!resetn)
        i_div_out_valid && !i_div_out_ready |=> i_div_out_valid && $stable(i_div_result))
        else $error("divider result dropped or changed before its grant");

endmodule

bind exec_core exec_core_assert exec_core_assert_inst (
    .clk             (clk),
    .resetn          (resetn),
    .i_wb_valid      (o_wb_valid),
    .i_wb_rd         (o_wb_rd),
    .i_div_valid     (div_valid),
    .i_div_busy      (div_busy),
    .i_alu_valid     (alu_bus.valid),
    .i_alu_ready     (alu_bus.ready),
    .i_alu_result    ({alu_bus.rd, alu_bus.data}),
    .i_mul_valid     (mul_bus.valid),
    .i_mul_ready     (mul_bus.ready),
    .i_mul_result    ({mul_bus.rd, mul_bus.data}),
    .i_div_out_valid (div_bus.valid),
    .i_div_out_ready (div_bus.ready),
    .i_div_result    ({div_bus.rd, div_bus.data})
);

//--- tb_exec_core.sv
`timescale 1ns/1ps

module tb_exec_core import core_cfg_pkg::*; import exec_op_pkg::*; ();

    logic                 clk = 1'b0;
    logic                 resetn;
    logic                 i_issue_valid;
    logic                 o_issue_ready;
    exec_op_e             i_issue_op;
    logic [REG_IDX_W-1:0] i_issue_rd;
    logic [REG_IDX_W-1:0] i_issue_rs1;
    logic [REG_IDX_W-1:0] i_issue_rs2;
    logic [XLEN-1:0]      i_issue_imm;
    logic                 o_wb_valid;
    logic [REG_IDX_W-1:0] o_wb_rd;
    logic [XLEN-1:0]      o_wb_data;

    // Stimulus table, one entry per row in each queue
    exec_op_e             row_op [$];
    logic [REG_IDX_W-1:0] row_rd [$];
    logic [REG_IDX_W-1:0] row_rs1 [$];
    logic [REG_IDX_W-1:0] row_rs2 [$];
    logic [XLEN-1:0]      row_imm [$];
    string                row_name [$];

    // Reference registers and the results still owed per rd
    logic [XLEN-1:0]      model_regs [NUM_REGS];
    logic [XLEN-1:0]      exp_value [NUM_REGS];
    string                exp_name [NUM_REGS];
    logic                 exp_open [NUM_REGS];
    int                   expected_total = 0;
    int                   received_count = 0;
    int                   cycle_count = 0;
    int                   cycle_limit = 200;
    int                   drain_cycles = 0;
    int                   seed;

    exec_core exec_core_inst (.*);

    always #5 clk = ~clk;

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [XLEN-1:0] expected,
                               input logic [XLEN-1:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
            stop_with_failure("writeback value mismatch");
        end
    endtask

    task automatic add_row(input exec_op_e op, input int rd, input int rs1, input int rs2,
                           input logic [XLEN-1:0] imm, input string name);
        row_op.push_back(op);
        row_rd.push_back(REG_IDX_W'(rd));
        row_rs1.push_back(REG_IDX_W'(rs1));
        row_rs2.push_back(REG_IDX_W'(rs2));
        row_imm.push_back(imm);
        row_name.push_back(name);
    endtask

    function automatic logic [XLEN-1:0] model_result(input exec_op_e op,
            input logic [XLEN-1:0] a, input logic [XLEN-1:0] b, input logic [XLEN-1:0] imm);
        logic signed [XLEN-1:0] sa;
        logic signed [XLEN-1:0] sb;
        logic signed [XLEN-1:0] squo;
        logic signed [XLEN-1:0] srem;
        logic [2*XLEN-1:0]      wide_a;
        logic [2*XLEN-1:0]      wide_b;
        logic [2*XLEN-1:0]      prod;
        logic                   overflow;
        sa = a;
        sb = b;
        wide_a = a;
        wide_b = b;
        prod = wide_a * wide_b;
        overflow = (a == {1'b1, {(XLEN-1){1'b0}}}) && (b == '1);
        // Signed quotient and remainder outside the zero and overflow cases
        squo = '0;
        srem = '0;
        if (b != '0 && !overflow) begin
            squo = sa / sb;
            srem = sa % sb;
        end
        case (op)
            OP_ADD:   return a + b;
            OP_SUB:   return a - b;
            OP_XOR:   return a ^ b;
            OP_MUL:   return prod[XLEN-1:0];
            OP_MULHU: return prod[2*XLEN-1:XLEN];
            OP_DIV:   return (b == '0) ? '1 : overflow ? a : squo;
            OP_DIVU:  return (b == '0) ? '1 : a / b;
            OP_REM:   return (b == '0) ? a : overflow ? '0 : srem;
            OP_REMU:  return (b == '0) ? a : a % b;
            default:  return imm;
        endcase
    endfunction

    task automatic build_table();
        exec_op_e mix_ops [4] = '{OP_MUL, OP_ADD, OP_MULHU, OP_XOR};
        add_row(OP_LI, 1, 0, 0, 32'd7, "li_x1");
        add_row(OP_LI, 2, 0, 0, 32'hffff_ffff, "li_x2");
        add_row(OP_LI, 3, 0, 0, 32'h8000_0000, "li_x3");
        add_row(OP_LI, 4, 0, 0, 32'd3, "li_x4");
        add_row(OP_LI, 5, 0, 0, 32'h1234_5678, "li_x5");
        add_row(OP_ADD, 6, 1, 2, '0, "add_wrap");
        add_row(OP_SUB, 7, 1, 4, '0, "sub_pos");
        add_row(OP_SUB, 8, 4, 1, '0, "sub_wrap");
        add_row(OP_XOR, 9, 5, 2, '0, "xor_ones");
        add_row(OP_ADD, 10, 0, 1, '0, "add_x0");
        add_row(OP_XOR, 11, 5, 0, '0, "xor_x0");
        add_row(OP_ADD, 12, 3, 3, '0, "add_min_wrap");
        add_row(OP_MUL, 13, 5, 1, '0, "mul_table");
        add_row(OP_MULHU, 14, 2, 2, '0, "mulhu_ones");
        add_row(OP_MUL, 15, 3, 2, '0, "mul_min_ones");
        for (int i = 0; i < 4; i++) begin
            add_row(OP_LI, 16 + i, 0, 0, $random(seed), $sformatf("li_rand_%0d", i));
        end
        add_row(OP_MUL, 18, 16, 17, '0, "mul_rand_a");
        add_row(OP_MULHU, 19, 16, 17, '0, "mulhu_rand_a");
        add_row(OP_MUL, 16, 18, 19, '0, "mul_rand_b");
        add_row(OP_MULHU, 17, 19, 18, '0, "mulhu_rand_b");
        add_row(OP_DIV, 20, 8, 4, '0, "div_neg");
        add_row(OP_DIVU, 21, 5, 4, '0, "divu_table");
        add_row(OP_REM, 22, 8, 4, '0, "rem_neg");
        add_row(OP_REMU, 23, 5, 1, '0, "remu_table");
        add_row(OP_DIV, 24, 5, 0, '0, "div_by_zero");
        add_row(OP_REM, 25, 5, 0, '0, "rem_by_zero");
        add_row(OP_DIVU, 26, 5, 0, '0, "divu_by_zero");
        add_row(OP_REMU, 27, 5, 0, '0, "remu_by_zero");
        add_row(OP_LI, 28, 0, 0, '1, "li_minus_one");
        add_row(OP_DIV, 29, 3, 28, '0, "div_overflow");
        add_row(OP_REM, 30, 3, 28, '0, "rem_overflow");
        // ADD reads the divide result while it is still in flight
        add_row(OP_DIV, 20, 5, 4, '0, "div_chain");
        add_row(OP_ADD, 21, 20, 1, '0, "add_after_div");
        // Multiplies and ALU ops issued while a divide runs
        add_row(OP_DIVU, 24, 2, 4, '0, "divu_background");
        for (int i = 0; i < 24; i++) begin
            add_row(mix_ops[i % 4], 6 + (i % 8), 16 + (i % 4), 19 - (i % 4), '0,
                    $sformatf("mix_%0d", i));
        end
        add_row(OP_ADD, 0, 1, 2, '0, "add_rd0");
        add_row(OP_MUL, 0, 5, 1, '0, "mul_rd0");
        add_row(OP_DIV, 0, 5, 4, '0, "div_rd0");
        add_row(OP_LI, 0, 0, 0, 32'hdead_beef, "li_rd0");
        add_row(OP_ADD, 31, 0, 1, '0, "read_x0_after_rd0");
    endtask

    task automatic issue_row(input int idx);
        logic [XLEN-1:0] result;
        i_issue_valid = 1'b1;
        i_issue_op = row_op[idx];
        i_issue_rd = row_rd[idx];
        i_issue_rs1 = row_rs1[idx];
        i_issue_rs2 = row_rs2[idx];
        i_issue_imm = row_imm[idx];
        #1;
        while (!o_issue_ready) begin
            @(negedge clk);
            #1;
        end
        // Accepted on the coming rising edge
        result = model_result(row_op[idx], model_regs[row_rs1[idx]],
                              model_regs[row_rs2[idx]], row_imm[idx]);
        if (row_rd[idx] != '0) begin
            model_regs[row_rd[idx]] = result;
            exp_value[row_rd[idx]] = result;
            exp_name[row_rd[idx]] = row_name[idx];
            exp_open[row_rd[idx]] = 1'b1;
            expected_total++;
        end
        @(negedge clk);
    endtask

    function automatic int outstanding_count();
        int n;
        n = 0;
        for (int i = 0; i < NUM_REGS; i++) begin
            if (exp_open[i]) begin
                n++;
            end
        end
        return n;
    endfunction

    always @(negedge clk) begin
        if (resetn && o_wb_valid) begin
            if (!exp_open[o_wb_rd]) begin
                stop_with_failure($sformatf("unexpected writeback to register %0d", o_wb_rd));
            end else begin
                check_value(exp_name[o_wb_rd], exp_value[o_wb_rd], o_wb_data);
                exp_open[o_wb_rd] = 1'b0;
                received_count++;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            stop_with_failure($sformatf("timeout after %0d cycles", cycle_count));
        end
    end

    initial begin
        resetn = 1'b0;
        i_issue_valid = 1'b0;
        i_issue_op = OP_LI;
        i_issue_rd = '0;
        i_issue_rs1 = '0;
        i_issue_rs2 = '0;
        i_issue_imm = '0;
        seed = 32'h32cdd7d6;
        for (int i = 0; i < NUM_REGS; i++) begin
            model_regs[i] = '0;
            exp_value[i] = '0;
            exp_open[i] = 1'b0;
        end
        build_table();
        cycle_limit = row_op.size() * (DIV_STEPS + 8) + 200;
        repeat (10) @(negedge clk);
        check_value("ready_in_reset", '0, XLEN'(o_issue_ready));
        resetn = 1'b1;
        @(negedge clk);
        check_value("ready_after_reset", XLEN'(1'b1), XLEN'(o_issue_ready));
        for (int r = 0; r < row_op.size(); r++) begin
            issue_row(r);
        end
        i_issue_valid = 1'b0;
        while (received_count != expected_total && drain_cycles < 4 * (DIV_STEPS + 8)) begin
            @(posedge clk);
            drain_cycles++;
        end
        // Room for any stray writeback to show up
        repeat (DIV_STEPS + 8) @(posedge clk);
        if (received_count == expected_total && outstanding_count() == 0) begin
            $display("No errors");
            $finish;
        end else begin
            stop_with_failure("not every expected writeback arrived");
        end
    end

endmodule

//--- verilog.f
core_cfg_pkg.sv
exec_op_pkg.sv
wb_bus_if.sv
reg_file.sv
issue_stage.sv
mul_unit.sv
div_unit.sv
wb_arbiter.sv
exec_core.sv
exec_core_assert.sv
tb_exec_core.sv

//--- run.sh
#!/bin/sh
verilator --binary --timing --assert --top-module tb_exec_core -f verilog.f || exit 1
./obj_dir/Vtb_exec_core > sim.log 2>&1
cat sim.log
grep -q "Errors found" sim.log && echo "Simulation FAILED" && exit 1
grep -q "No errors" sim.log || { echo "Simulation did not complete"; exit 1; }
echo "Simulation PASSED"
